//--- rtl/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic [15:0] sample_t;

    // Audio RAM geometry, channel in the upper address bits
    localparam int CHANNELS = 8;
    localparam int CHAN_W   = 3;
    localparam int FRAMES   = 256;
    localparam int FRAME_W  = 8;
    localparam int AUDIO_W  = CHAN_W + FRAME_W;

    // I2S frame is 64 bit slots, two half frames of 32
    localparam int FRAME_BITS = 64;
    localparam int POSN_W     = 6;

    // Bus block codes, matched against address bits 31..24
    localparam logic [7:0] BLK_BASE  = 8'h60;
    localparam logic [7:0] blk_regs  = BLK_BASE + 8'h02;
    localparam logic [7:0] blk_audio = BLK_BASE + 8'h04;

    typedef enum logic [2:0] {
        reg_control = 3'd0,
        reg_status  = 3'd1,
        reg_offsets = 3'd4,
        reg_left    = 3'd5,
        reg_right   = 3'd6
    } reg_index_t;

    typedef enum logic {
        cap_idle,
        cap_writing
    } capture_state_t;

endpackage

`default_nettype wire

//--- rtl/i2s_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_clock_gen #(
    parameter int CLK_DIV = 8
) (
    input  wire                         ck,
    input  wire                         reset,
    input  wire  [3:0]                  in_offset,
    input  wire  [3:0]                  out_offset,
    output logic                        sck,
    output logic                        ws,
    output logic [audio_pkg::POSN_W-1:0] posn,
    output logic                        frame_start,
    output logic                        in_sample,
    output logic                        out_sample
);

    import audio_pkg::*;

    // Divider wide enough to compare against the 4 bit offsets
    localparam int DIV_W = $clog2(CLK_DIV);
    localparam int CNT_W = (DIV_W > 4) ? DIV_W : 4;

    logic [CNT_W-1:0] div;
    logic             last_cycle;
    logic             last_posn;

    assign last_cycle = (div == CNT_W'(CLK_DIV - 1));
    assign last_posn  = (posn == POSN_W'(FRAME_BITS - 1));

    always_ff @(posedge ck) begin
        if (reset) begin
            div         <= '0;
            posn        <= '0;
            frame_start <= 1'b0;
        end else begin
            // Flags the wrap into slot 0, so the partial frame after reset is skipped
            frame_start <= last_cycle && last_posn;
            if (last_cycle) begin
                div  <= '0;
                posn <= posn + 1'b1;
            end else begin
                div <= div + 1'b1;
            end
        end
    end

    // Low for the first half of each bit
    assign sck = (div >= CNT_W'(CLK_DIV / 2));

    // Left half of the frame while ws is low
    assign ws = (posn >= POSN_W'(FRAME_BITS / 2));

    // Sample points delayed from the start of each bit
    assign in_sample  = (div == CNT_W'(in_offset));
    assign out_sample = (div == CNT_W'(out_offset));

endmodule

`default_nettype wire

//--- rtl/i2s_rx.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_rx (
    input  wire                          ck,
    input  wire                          reset,
    input  wire                          sample,
    input  wire  [audio_pkg::POSN_W-1:0] posn,
    input  wire                          sd,
    output audio_pkg::sample_t           left,
    output audio_pkg::sample_t           right
);

    import audio_pkg::*;

    localparam int WORD_BITS = $bits(sample_t);

    logic [POSN_W-2:0] slot;
    logic              in_word;
    logic              last_bit;
    sample_t           shift;
    sample_t           shift_next;

    // Slot within the current half frame
    assign slot       = posn[POSN_W-2:0];
    assign in_word    = (slot != '0) && (slot <= (POSN_W-1)'(WORD_BITS));
    assign last_bit   = (slot == (POSN_W-1)'(WORD_BITS));
    assign shift_next = {shift[WORD_BITS-2:0], sd};

    always_ff @(posedge ck) begin
        if (sample && in_word) begin
            shift <= shift_next;
        end
    end

    always_ff @(posedge ck) begin
        if (reset) begin
            left  <= '0;
            right <= '0;
        end else if (sample && last_bit) begin
            // Upper half of the frame carries the right word
            if (posn[POSN_W-1]) begin
                right <= shift_next;
            end else begin
                left <= shift_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2s_tx.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_tx (
    input  wire                          ck,
    input  wire                          reset,
    input  wire                          sample,
    input  wire  [audio_pkg::POSN_W-1:0] posn,
    input  wire  audio_pkg::sample_t     left,
    input  wire  audio_pkg::sample_t     right,
    output logic                         sd_out
);

    import audio_pkg::*;

    localparam int WORD_BITS = $bits(sample_t);

    logic [POSN_W-1:0] posn_q;
    logic [POSN_W-2:0] slot;
    logic              in_word;
    logic              half_start;
    sample_t           shift;

    assign slot    = posn[POSN_W-2:0];
    assign in_word = (slot != '0) && (slot <= (POSN_W-1)'(WORD_BITS));

    // First cycle of slot 0 or slot 32
    assign half_start = (slot == '0) && (posn != posn_q);

    always_ff @(posedge ck) begin
        if (reset) begin
            shift <= '0;
        end else if (half_start) begin
            shift <= posn[POSN_W-1] ? right : left;
        end else if (sample && in_word) begin
            shift <= shift << 1;
        end
    end

    always_ff @(posedge ck) begin
        if (reset) begin
            posn_q <= '0;
            sd_out <= 1'b0;
        end else begin
            posn_q <= posn;
            if (sample) begin
                sd_out <= in_word ? shift[WORD_BITS-1] : 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
    input  wire                           ck,
    input  wire                           reset,
    input  wire                           frame_start,
    input  wire                           write_mode,
    input  wire  audio_pkg::sample_t      mic [audio_pkg::CHANNELS],
    output logic                          cap_we,
    output logic [audio_pkg::AUDIO_W-1:0] cap_addr,
    output audio_pkg::sample_t            cap_data,
    output logic [audio_pkg::FRAME_W-1:0] frame_count
);

    import audio_pkg::*;

    capture_state_t    state;
    logic [CHAN_W-1:0] chan;

    always_ff @(posedge ck) begin
        if (reset) begin
            state       <= cap_idle;
            chan        <= '0;
            frame_count <= '0;
        end else begin
            case (state)
                cap_idle: begin
                    // Host owns the RAM in write mode, so the counter holds
                    if (frame_start && !write_mode) begin
                        frame_count <= frame_count - 1'b1;
                        chan        <= '0;
                        state       <= cap_writing;
                    end
                end
                cap_writing: begin
                    chan <= chan + 1'b1;
                    if (chan == CHAN_W'(CHANNELS - 1)) begin
                        state <= cap_idle;
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase
        end
    end

    // One channel per cycle into the new frame
    assign cap_we   = (state == cap_writing);
    assign cap_addr = {chan, frame_count};
    assign cap_data = mic[chan];

endmodule

`default_nettype wire

//--- rtl/audio_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module audio_ram_arbiter (
    input  wire                           ck,
    input  wire                           write_mode,
    input  wire                           cap_we,
    input  wire  [audio_pkg::AUDIO_W-1:0] cap_addr,
    input  wire  audio_pkg::sample_t      cap_data,
    input  wire                           host_we,
    input  wire  [audio_pkg::AUDIO_W-1:0] host_addr,
    input  wire  audio_pkg::sample_t      host_data,
    input  wire  [audio_pkg::AUDIO_W-1:0] host_raddr,
    output audio_pkg::sample_t            ram_rdata
);

    import audio_pkg::*;

    sample_t mem [FRAMES * CHANNELS];

    logic               we;
    logic [AUDIO_W-1:0] waddr;
    sample_t            wdata;

    // Write port goes to the host only in write mode
    assign we    = write_mode ? host_we   : cap_we;
    assign waddr = write_mode ? host_addr : cap_addr;
    assign wdata = write_mode ? host_data : cap_data;

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port is the host's alone
    always_ff @(posedge ck) begin
        ram_rdata <= mem[host_raddr];
    end

endmodule

`default_nettype wire

//--- rtl/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs (
    input  wire                           ck,
    input  wire                           reset,
    input  wire                           bus_cyc,
    input  wire                           bus_we,
    input  wire  [31:0]                   bus_adr,
    input  wire  [31:0]                   bus_dat,
    input  wire  [audio_pkg::FRAME_W-1:0] frame_count,
    input  wire  audio_pkg::sample_t      ram_rdata,
    output logic                          ack,
    output logic [31:0]                   rdt,
    output logic                          write_mode,
    output logic [3:0]                    in_offset,
    output logic [3:0]                    out_offset,
    output audio_pkg::sample_t            out_left,
    output audio_pkg::sample_t            out_right,
    output logic                          host_we,
    output logic [audio_pkg::AUDIO_W-1:0] host_addr,
    output audio_pkg::sample_t            host_data,
    output logic [audio_pkg::AUDIO_W-1:0] host_raddr
);

    import audio_pkg::*;

    logic [7:0]         blk;
    logic               hit_regs;
    logic               hit_audio;
    logic               cyc_seen;
    logic               strobe;
    reg_index_t         index;
    logic [FRAME_W-1:0] frame_reg;
    logic [31:0]        reg_rdata;

    assign blk       = bus_adr[31:24];
    assign hit_regs  = bus_cyc && (blk == blk_regs);
    assign hit_audio = bus_cyc && (blk == blk_audio);
    assign index     = reg_index_t'(bus_adr[4:2]);

    // Only the first cycle of a bus cycle acts
    assign strobe = (hit_regs || hit_audio) && !cyc_seen;

    always_ff @(posedge ck) begin
        if (reset) begin
            ack      <= 1'b0;
            cyc_seen <= 1'b0;
        end else begin
            ack      <= strobe;
            cyc_seen <= bus_cyc;
        end
    end

    always_ff @(posedge ck) begin
        if (reset) begin
            write_mode <= 1'b0;
            frame_reg  <= '0;
            in_offset  <= '0;
            out_offset <= '0;
            out_left   <= '0;
            out_right  <= '0;
        end else if (strobe && bus_we && hit_regs) begin
            case (index)
                reg_control: begin
                    write_mode <= bus_dat[0];
                    frame_reg  <= bus_dat[FRAME_W+1:2];
                end
                reg_offsets: begin
                    in_offset  <= bus_dat[3:0];
                    out_offset <= bus_dat[7:4];
                end
                reg_left: begin
                    out_left <= bus_dat[$bits(sample_t)-1:0];
                end
                reg_right: begin
                    out_right <= bus_dat[$bits(sample_t)-1:0];
                end
                // Status is read only
                default: begin
                end
            endcase
        end
    end

    // Audio RAM word address from bits 12..2
    assign host_we    = strobe && bus_we && hit_audio;
    assign host_addr  = bus_adr[AUDIO_W+1:2];
    assign host_data  = bus_dat[$bits(sample_t)-1:0];
    assign host_raddr = bus_adr[AUDIO_W+1:2];

    always_comb begin
        case (index)
            reg_control: reg_rdata = 32'({frame_reg, 1'b0, write_mode});
            reg_status:  reg_rdata = 32'(frame_count);
            reg_offsets: reg_rdata = 32'({out_offset, in_offset});
            reg_left:    reg_rdata = 32'(out_left);
            reg_right:   reg_rdata = 32'(out_right);
            default:     reg_rdata = '0;
        endcase
    end

    // RAM word arrives in the ack cycle, address still held by the host
    always_comb begin
        rdt = '0;
        if (ack && !bus_we) begin
            rdt = hit_audio ? 32'(ram_rdata) : reg_rdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/audio_engine.sv
`timescale 1ns/1ps
`default_nettype none

module audio_engine #(
    parameter int CLK_DIV = 8
) (
    input  wire         ck,
    input  wire         reset,
    input  wire         bus_cyc,
    input  wire         bus_we,
    input  wire  [31:0] bus_adr,
    input  wire  [31:0] bus_dat,
    input  wire  [3:0]  sd_in,
    output logic        ack,
    output logic [31:0] rdt,
    output logic        sck,
    output logic        ws,
    output logic        sd_out
);

    import audio_pkg::*;

    logic [POSN_W-1:0]  posn;
    logic               frame_start;
    logic               in_sample;
    logic               out_sample;
    logic [3:0]         in_offset;
    logic [3:0]         out_offset;
    sample_t            mic [CHANNELS];
    sample_t            out_left;
    sample_t            out_right;
    logic               write_mode;
    logic [FRAME_W-1:0] frame_count;
    logic               cap_we;
    logic [AUDIO_W-1:0] cap_addr;
    sample_t            cap_data;
    logic               host_we;
    logic [AUDIO_W-1:0] host_addr;
    sample_t            host_data;
    logic [AUDIO_W-1:0] host_raddr;
    sample_t            ram_rdata;

    i2s_clock_gen #(
        .CLK_DIV(CLK_DIV)
    ) u_clock_gen (
        .ck(ck),
        .reset(reset),
        .in_offset(in_offset),
        .out_offset(out_offset),
        .sck(sck),
        .ws(ws),
        .posn(posn),
        .frame_start(frame_start),
        .in_sample(in_sample),
        .out_sample(out_sample)
    );

    // Lane k gives channels 2k and 2k+1
    for (genvar k = 0; k < CHANNELS / 2; k++) begin : g_rx
        i2s_rx u_rx (
            .ck(ck),
            .reset(reset),
            .sample(in_sample),
            .posn(posn),
            .sd(sd_in[k]),
            .left(mic[2*k]),
            .right(mic[2*k+1])
        );
    end

    i2s_tx u_tx (
        .ck(ck),
        .reset(reset),
        .sample(out_sample),
        .posn(posn),
        .left(out_left),
        .right(out_right),
        .sd_out(sd_out)
    );

    frame_capture u_capture (
        .ck(ck),
        .reset(reset),
        .frame_start(frame_start),
        .write_mode(write_mode),
        .mic(mic),
        .cap_we(cap_we),
        .cap_addr(cap_addr),
        .cap_data(cap_data),
        .frame_count(frame_count)
    );

    audio_ram_arbiter u_ram (
        .ck(ck),
        .write_mode(write_mode),
        .cap_we(cap_we),
        .cap_addr(cap_addr),
        .cap_data(cap_data),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_data(host_data),
        .host_raddr(host_raddr),
        .ram_rdata(ram_rdata)
    );

    host_regs u_regs (
        .ck(ck),
        .reset(reset),
        .bus_cyc(bus_cyc),
        .bus_we(bus_we),
        .bus_adr(bus_adr),
        .bus_dat(bus_dat),
        .frame_count(frame_count),
        .ram_rdata(ram_rdata),
        .ack(ack),
        .rdt(rdt),
        .write_mode(write_mode),
        .in_offset(in_offset),
        .out_offset(out_offset),
        .out_left(out_left),
        .out_right(out_right),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_data(host_data),
        .host_raddr(host_raddr)
    );

endmodule

`default_nettype wire

//--- bench/tb_audio_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_audio_engine;

    localparam int CLK_DIV      = 8;
    localparam int FRAME_CYCLES = 64 * CLK_DIV;
    localparam int MAX_STEPS    = 128;

    // Step kinds in the input file
    localparam logic [31:0] STEP_END       = 32'h0;
    localparam logic [31:0] STEP_REG_WRITE = 32'h1;
    localparam logic [31:0] STEP_REG_READ  = 32'h2;
    localparam logic [31:0] STEP_RAM_WRITE = 32'h3;
    localparam logic [31:0] STEP_RAM_READ  = 32'h4;
    localparam logic [31:0] STEP_LANE      = 32'h5;
    localparam logic [31:0] STEP_SEND      = 32'h6;
    localparam logic [31:0] STEP_EXPECT    = 32'h7;
    localparam logic [31:0] STEP_WAIT      = 32'h8;

    logic        ck = 1'b0;
    logic        reset;
    logic        bus_cyc;
    logic        bus_we;
    logic [31:0] bus_adr;
    logic [31:0] bus_dat;
    logic [3:0]  sd_in;
    wire         ack;
    wire  [31:0] rdt;
    wire         sck;
    wire         ws;
    wire         sd_out;

    logic [31:0] steps [3*MAX_STEPS];
    logic [15:0] lane_left [4];
    logic [15:0] lane_right [4];
    integer      seed = 32'hfb84_0c0a;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;

    audio_engine #(
        .CLK_DIV(CLK_DIV)
    ) u_audio_engine (
        .ck(ck),
        .reset(reset),
        .bus_cyc(bus_cyc),
        .bus_we(bus_we),
        .bus_adr(bus_adr),
        .bus_dat(bus_dat),
        .sd_in(sd_in),
        .ack(ack),
        .rdt(rdt),
        .sck(sck),
        .ws(ws),
        .sd_out(sd_out)
    );

    always #20 ck = ~ck;

    // Run limit set once the step count is known
    always @(posedge ck) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT did not finish the steps", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One bus cycle, held through the ack cycle, then ack and rdt must drop
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              output logic [31:0] data_out);
        @(negedge ck);
        bus_cyc = 1'b1;
        bus_we  = we;
        bus_adr = adr;
        bus_dat = dat;
        @(negedge ck);
        while (ack !== 1'b1) begin
            @(negedge ck);
        end
        data_out = rdt;
        @(negedge ck);
        compare_value("ack is a single pulse", {31'b0, ack}, 32'h0);
        compare_value("rdt outside ack", rdt, 32'h0);
        bus_cyc = 1'b0;
        bus_we  = 1'b0;
    endtask

    // Returns in the first cycle of position 0
    task automatic wait_frame_start();
        @(negedge ws);
        @(negedge ck);
    endtask

    // All four lanes, new bit at each sck fall, filler between words
    task automatic send_frame();
        logic [3:0]  bits;
        logic [31:0] rnd;
        wait_frame_start();
        for (int p = 1; p <= 48; p++) begin
            @(negedge sck);
            @(negedge ck);
            rnd  = $random(seed);
            bits = rnd[3:0];
            for (int k = 0; k < 4; k++) begin
                if (p <= 16) begin
                    bits[k] = lane_left[k][16 - p];
                end else if (p >= 33) begin
                    bits[k] = lane_right[k][48 - p];
                end
            end
            sd_in = bits;
        end
    endtask

    task automatic expect_output(input logic [31:0] exp);
        logic [15:0] left_word;
        logic [15:0] right_word;
        logic        stray;
        logic        ws_bad;
        logic        sck_bad;
        left_word  = '0;
        right_word = '0;
        stray      = 1'b0;
        ws_bad     = 1'b0;
        sck_bad    = 1'b0;
        wait_frame_start();
        for (int k = 1; k <= 49; k++) begin
            @(negedge sck);
            @(negedge ck);
            ws_bad = ws_bad | (ws !== (k >= 32));
            // sd_out still holds the bit of the previous position
            if (k - 1 >= 1 && k - 1 <= 16) begin
                left_word = {left_word[14:0], sd_out};
            end else if (k - 1 >= 33) begin
                right_word = {right_word[14:0], sd_out};
            end else begin
                stray = stray | sd_out;
            end
            // sck low through the first half of the bit, high after
            repeat (CLK_DIV / 2 - 1) @(negedge ck);
            sck_bad = sck_bad | (sck !== 1'b0);
            @(negedge ck);
            sck_bad = sck_bad | (sck !== 1'b1);
        end
        compare_value("sd_out left word", {16'h0, left_word}, {16'h0, exp[31:16]});
        compare_value("sd_out right word", {16'h0, right_word}, {16'h0, exp[15:0]});
        compare_value("sd_out outside data bits", {31'b0, stray}, 32'h0);
        compare_value("ws against bit position", {31'b0, ws_bad}, 32'h0);
        compare_value("sck phase within each bit", {31'b0, sck_bad}, 32'h0);
    endtask

    initial begin
        logic [31:0] kind;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] got;
        int          n;
        reset   = 1'b1;
        bus_cyc = 1'b0;
        bus_we  = 1'b0;
        bus_adr = '0;
        bus_dat = '0;
        sd_in   = 4'h0;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        limit   = 0;
        for (int i = 0; i < 3 * MAX_STEPS; i++) begin
            steps[i] = '0;
        end
        $readmemh("bench/audio_engine_input.txt", steps);
        n = 0;
        while (n < MAX_STEPS && steps[3*n] != STEP_END) begin
            n++;
        end
        // Frame steps can take up to two frames each
        limit = (n + 1) * 2 * FRAME_CYCLES;

        repeat (4) @(negedge ck);
        reset = 1'b0;
        @(negedge ck);
        compare_value("ack after reset", {31'b0, ack}, 32'h0);
        compare_value("ws after reset", {31'b0, ws}, 32'h0);
        compare_value("sd_out after reset", {31'b0, sd_out}, 32'h0);

        for (int s = 0; s < n; s++) begin
            kind = steps[3*s];
            adr  = steps[3*s+1];
            dat  = steps[3*s+2];
            case (kind)
                STEP_REG_WRITE, STEP_RAM_WRITE: begin
                    bus_access(1'b1, adr, dat, got);
                end
                STEP_REG_READ: begin
                    bus_access(1'b0, adr, 32'h0, got);
                    compare_value($sformatf("register read at %h", adr), got, dat);
                end
                STEP_RAM_READ: begin
                    bus_access(1'b0, adr, 32'h0, got);
                    compare_value($sformatf("audio RAM read at %h", adr), got, dat);
                end
                STEP_LANE: begin
                    lane_left[adr[1:0]]  = dat[31:16];
                    lane_right[adr[1:0]] = dat[15:0];
                end
                STEP_SEND: begin
                    send_frame();
                end
                STEP_EXPECT: begin
                    expect_output(dat);
                end
                STEP_WAIT: begin
                    // Room for the eight capture writes
                    wait_frame_start();
                    repeat (12) @(negedge ck);
                end
                default: begin
                    errors++;
                    $display("Unknown step kind %h at step %0d in the input file", kind, s);
                end
            endcase
        end

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/audio_engine_input.txt
// Columns: kind address data, all hex
// Kinds: 1 reg write, 2 reg read and expect, 3 RAM write, 4 RAM read and expect,
// 5 lane words (address = lane, data = left:right), 6 send frame,
// 7 expect output (data = left:right), 8 wait frame start, 0 end
2 62000000 00000000
2 62000004 00000000
2 62000010 00000000
2 62000014 00000000
2 62000018 00000000
// Write mode before the first frame start holds the counter at 0
1 62000000 000003fd
2 62000000 000003fd
1 62000010 00000021
2 62000010 00000021
2 62000004 00000000
// First frame, write mode dropped before it ends
5 00000000 9a011b82
5 00000001 c3a55a3c
5 00000002 ffff0001
5 00000003 80007e7e
6 00000000 00000000
1 62000000 00000000
// Second frame
5 00000000 12345678
5 00000001 9abcdef0
5 00000002 0f0ff0f0
5 00000003 3333cccc
6 00000000 00000000
8 00000000 00000000
2 62000004 000000fe
// Frame 255 holds the first frame, channel 2k/2k+1 = lane k left/right
4 640003fc 00009a01
4 640007fc 00001b82
4 64000bfc 0000c3a5
4 64000ffc 00005a3c
4 640013fc 0000ffff
4 640017fc 00000001
4 64001bfc 00008000
4 64001ffc 00007e7e
4 640003f8 00001234
4 64001ff8 0000cccc
// Host writes in write mode, counter must hold
1 62000000 00000001
2 62000000 00000001
3 64000c40 0000beef
3 64001ffc 00001234
4 64000c40 0000beef
4 64001ffc 00001234
8 00000000 00000000
8 00000000 00000000
2 62000004 000000fe
// Output pair
1 62000014 0000a5c3
1 62000018 00006e91
2 62000014 0000a5c3
2 62000018 00006e91
7 00000000 a5c36e91
0 00000000 00000000

//--- files.f
rtl/audio_pkg.sv
rtl/i2s_clock_gen.sv
rtl/i2s_rx.sv
rtl/i2s_tx.sv
rtl/frame_capture.sv
rtl/audio_ram_arbiter.sv
rtl/host_regs.sv
rtl/audio_engine.sv
bench/tb_audio_engine.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_audio_engine
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
